// ==== hdl/dcachePkg.sv ====
`include "l1Dcache_defs.svh"

package dcachePkg;

	// byte address as seen on adr_i
	typedef logic [`ADDR_W-1:0] addrT;

	// upper address bits kept in the tag store
	typedef logic [`TAG_W-1:0] tagT;

	// set number inside a way
	typedef logic [`SET_W-1:0] setIdxT;

	// full cache line, byte k lives at bits 8k+7:8k
	typedef logic [`LINE_BYTES*8-1:0] lineT;

	// one write enable per byte of a line
	typedef logic [`LINE_BYTES-1:0] byteSelT;

	// read result, two bytes low byte first
	typedef logic [15:0] wordT;

	// one flag per way
	typedef logic [`WAYS-1:0] wayVecT;

endpackage

// ==== hdl/dcacheWay.sv ====
`include "l1Dcache_defs.svh"

module dcacheWay
	import dcachePkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  setIdxT  setIdx_i,
	input  tagT     tag_i,
	input  logic    wr_i,
	input  byteSelT sel_i,
	input  lineT    wdata_i,
	input  logic    invLine_i,
	input  logic    invAll_i,
	output logic    hit_o,
	output logic    valid_o,
	output lineT    line_o
);

	// --------------------------------------------------------------------------
	// storage
	// --------------------------------------------------------------------------

	// tag per set, distributed RAM style
	tagT tagMem [`SETS];

	// line data per set, written byte by byte
	lineT lineMem [`SETS];

	// valid flags sit in flops so reset and invalidate-all are one cycle
	logic [`SETS-1:0] validBits;

	tagT storedTag;

	// write qualifiers
	logic invAny;
	logic doWrite;
	logic doAlloc;

	// --------------------------------------------------------------------------
	// lookup
	// --------------------------------------------------------------------------

	// asynchronous read of the indexed set
	assign storedTag = tagMem[setIdx_i];
	assign valid_o = validBits[setIdx_i];
	assign line_o = lineMem[setIdx_i];

	assign hit_o = valid_o && (storedTag == tag_i);

	// --------------------------------------------------------------------------
	// update
	// --------------------------------------------------------------------------

	// any invalidation blocks the write in the same cycle
	assign invAny = invAll_i | invLine_i;
	assign doWrite = wr_i & ~invAny;

	// a write enable on a way that misses means this way was picked as victim
	assign doAlloc = doWrite & ~hit_o;

	always_ff @(posedge clk) begin
		if (rst)
			validBits <= '0;
		else if (invAll_i)
			validBits <= '0;
		// only the way holding the address drops it
		else if (invLine_i && hit_o)
			validBits[setIdx_i] <= 1'b0;
		else if (doAlloc)
			validBits[setIdx_i] <= 1'b1;
	end

	// new tag only on allocation, a write hit keeps the tag as is
	always_ff @(posedge clk) begin
		if (doAlloc)
			tagMem[setIdx_i] <= tag_i;
	end

	// byte lanes with their own enables
	// on allocation the unselected bytes keep whatever the old line had
	always_ff @(posedge clk) begin
		if (doWrite) begin
			for (int b = 0; b < `LINE_BYTES; b++) begin
				if (sel_i[b])
					lineMem[setIdx_i][8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
	end

endmodule

// ==== hdl/l1Dcache.sv ====
`include "l1Dcache_defs.svh"

module l1Dcache
	import dcachePkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  addrT    adr_i,
	input  logic    wr_i,
	input  byteSelT sel_i,
	input  lineT    wdata_i,
	input  logic    nxt_i,
	input  logic    invLine_i,
	input  logic    invAll_i,
	output logic    hit_o,
	output wordT    rdata_o
);

	// address fields
	tagT tag;
	setIdxT setIdx;
	logic [`OFFS_W-1:0] offset;

	// per way status, one bit each
	wayVecT wayHit;
	wayVecT wayValid;
	wayVecT wayWr;

	// indexed line from every way
	lineT wayLine [`WAYS];

	// tag | set | offset
	assign tag = adr_i[`ADDR_W-1 -: `TAG_W];
	assign setIdx = adr_i[`OFFS_W +: `SET_W];
	assign offset = adr_i[`OFFS_W-1:0];

	// --------------------------------------------------------------------------
	// victim and write steering
	// --------------------------------------------------------------------------

	victimSelect u0 (
		.clk       (clk),
		.rst       (rst),
		.nxt_i     (nxt_i),
		.wr_i      (wr_i),
		.wayHit_i  (wayHit),
		.wayValid_i(wayValid),
		.wayWr_o   (wayWr)
	);

	// --------------------------------------------------------------------------
	// the ways
	// --------------------------------------------------------------------------

	for (genvar w = 0; w < `WAYS; w++) begin : way
		dcacheWay u (
			.clk      (clk),
			.rst      (rst),
			.setIdx_i (setIdx),
			.tag_i    (tag),
			.wr_i     (wayWr[w]),
			.sel_i    (sel_i),
			.wdata_i  (wdata_i),
			.invLine_i(invLine_i),
			.invAll_i (invAll_i),
			.hit_o    (wayHit[w]),
			.valid_o  (wayValid[w]),
			.line_o   (wayLine[w])
		);
	end

	// read side is purely combinational
	wayReadMux u1 (
		.wayHit_i (wayHit),
		.wayLine_i(wayLine),
		.offset_i (offset),
		.hit_o    (hit_o),
		.rdata_o  (rdata_o)
	);

endmodule

// ==== hdl/victimSelect.sv ====
`include "l1Dcache_defs.svh"

module victimSelect
	import dcachePkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   nxt_i,
	input  logic   wr_i,
	input  wayVecT wayHit_i,
	input  wayVecT wayValid_i,
	output wayVecT wayWr_o
);

	// bits of the LFSR needed to name a way
	localparam int WAY_SEL_W = $clog2(`WAYS);

	logic [`LFSR_W-1:0] lfsr;
	wayVecT invalidVec;
	wayVecT firstInvalid;
	wayVecT randomWay;

	// --------------------------------------------------------------------------
	// replacement LFSR
	// --------------------------------------------------------------------------

	// galois form, the bit shifted out folds back through the tap mask
	always_ff @(posedge clk) begin
		if (rst)
			lfsr <= `LFSR_SEED;
		else if (nxt_i)
			lfsr <= {1'b0, lfsr[`LFSR_W-1:1]} ^ ({`LFSR_W{lfsr[0]}} & `LFSR_TAPS);
	end

	// --------------------------------------------------------------------------
	// victim choice
	// --------------------------------------------------------------------------

	// isolate the lowest set bit of the invalid vector
	assign invalidVec = ~wayValid_i;
	assign firstInvalid = invalidVec & (~invalidVec + wayVecT'(1));

	// only used when every way at this set is occupied
	assign randomWay = wayVecT'(1) << lfsr[WAY_SEL_W-1:0];

	always_comb begin
		if (!wr_i)
			wayWr_o = '0;
		// write hit stays in the hitting way
		else if (|wayHit_i)
			wayWr_o = wayHit_i;
		// fill a free slot before evicting anything
		else if (!(&wayValid_i))
			wayWr_o = firstInvalid;
		else
			wayWr_o = randomWay;
	end

endmodule

// ==== hdl/wayReadMux.sv ====
`include "l1Dcache_defs.svh"

module wayReadMux
	import dcachePkg::*;
(
	input  wayVecT             wayHit_i,
	input  lineT               wayLine_i [`WAYS],
	input  logic [`OFFS_W-1:0] offset_i,
	output logic               hit_o,
	output wordT               rdata_o
);

	// line of the hitting way, all zero on a miss
	lineT hitLine;

	// line moved down so the addressed byte lands at bit 0
	lineT shiftedLine;

	// --------------------------------------------------------------------------
	// hit and way select
	// --------------------------------------------------------------------------

	assign hit_o = |wayHit_i;

	// walk from the top so the lowest hitting way wins
	always_comb begin
		hitLine = '0;
		for (int w = `WAYS - 1; w >= 0; w--) begin
			if (wayHit_i[w])
				hitLine = wayLine_i[w];
		end
	end

	// --------------------------------------------------------------------------
	// word extraction
	// --------------------------------------------------------------------------

	// offset counts bytes, so scale by eight
	// the shift fills with zeros which gives the zero byte past the line end
	assign shiftedLine = hitLine >> {offset_i, 3'b000};

	// low byte of the word is the byte at the offset
	assign rdata_o = shiftedLine[15:0];

endmodule

// ==== include/l1Dcache_defs.svh ====
`ifndef L1DCACHE_DEFS_SVH
`define L1DCACHE_DEFS_SVH

// byte address width
`define ADDR_W 32

// line geometry, 16 bytes per line so 4 offset bits
`define LINE_BYTES 16
`define OFFS_W 4

// sets per way and the index width
`define SETS 8
`define SET_W 3

// associativity
`define WAYS 4

// tag is whatever is left above set index and offset
`define TAG_W (`ADDR_W - `SET_W - `OFFS_W)

// replacement LFSR, galois form shifting right
`define LFSR_W 16
`define LFSR_SEED 16'hACE1
// x^16 + x^14 + x^13 + x^11 + 1
`define LFSR_TAPS 16'hB400

`endif

// ==== l1Dcache.f ====
+incdir+include
hdl/dcachePkg.sv
hdl/victimSelect.sv
hdl/dcacheWay.sv
hdl/wayReadMux.sv
hdl/l1Dcache.sv
test/l1DcacheProperties.sv
test/l1DcacheTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f l1Dcache.f --top-module l1DcacheTb \
	-o simv > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

// ==== test/l1DcacheProperties.sv ====
`include "l1Dcache_defs.svh"

module l1DcacheProperties
	import dcachePkg::*;
(
	input logic   clk,
	input logic   rst,
	input logic   wr_i,
	input logic   invAll_i,
	input logic   hit_o,
	input wayVecT wayWr,
	input wayVecT wayHit
);

	// --------------------------------------------------------------------------
	// write steering
	// --------------------------------------------------------------------------

	// at most one way may take a write
	wrOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(wayWr))
		else $error("way write enable is not one-hot");

	// no strobe, no write enable
	wrIdle: assert property (@(posedge clk) disable iff (rst) !wr_i |-> wayWr == '0)
		else $error("way write enable without a write strobe");

	// --------------------------------------------------------------------------
	// lookup
	// --------------------------------------------------------------------------

	// everything is invalid one cycle after a flush
	flushMiss: assert property (@(posedge clk) disable iff (rst) invAll_i |=> !hit_o)
		else $error("hit right after invalidate-all");

	// a tag lives in one way only
	hitUnique: assert property (@(posedge clk) disable iff (rst) $onehot0(wayHit))
		else $error("more than one way hits");

endmodule

bind l1Dcache l1DcacheProperties props (
	.clk     (clk),
	.rst     (rst),
	.wr_i    (wr_i),
	.invAll_i(invAll_i),
	.hit_o   (hit_o),
	.wayWr   (wayWr),
	.wayHit  (wayHit)
);

// ==== test/l1DcacheTb.sv ====
`include "l1Dcache_defs.svh"

module l1DcacheTb
	import dcachePkg::*;
();

	localparam int MAX_CYCLES = 20000;

	logic clk;
	logic rst;
	addrT adr_i;
	logic wr_i;
	byteSelT sel_i;
	lineT wdata_i;
	logic nxt_i;
	logic invLine_i;
	logic invAll_i;
	logic hit_o;
	wordT rdata_o;

	// compare process only looks at cycles flagged here
	logic checkEn;
	logic done;
	int errors;
	int checks;
	logic [31:0] seed;

	// reference model with four ways per set
	tagT mTag [`SETS][`WAYS];
	logic mValid [`SETS][`WAYS];
	lineT mLine [`SETS][`WAYS];
	// set where the LFSR picked a victim so its contents are unknown
	logic uncertain [`SETS];

	// addresses per set with slot 4 holding the fifth tag
	addrT addrTab [`SETS][5];

	l1Dcache dut_i (
		.clk      (clk),
		.rst      (rst),
		.adr_i    (adr_i),
		.wr_i     (wr_i),
		.sel_i    (sel_i),
		.wdata_i  (wdata_i),
		.nxt_i    (nxt_i),
		.invLine_i(invLine_i),
		.invAll_i (invAll_i),
		.hit_o    (hit_o),
		.rdata_o  (rdata_o)
	);

	always #50 clk = ~clk;

	// --------------------------------------------------------------------------
	// stimulus helpers and reference model
	// --------------------------------------------------------------------------

	function logic [31:0] nextRand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function lineT randLine();
		return {nextRand(), nextRand(), nextRand(), nextRand()};
	endfunction

	// expected {hit, word} for an address
	function logic [16:0] refRead(addrT a);
		int s;
		int off;
		logic [7:0] lo;
		logic [7:0] hi;
		s = int'(a[`OFFS_W +: `SET_W]);
		off = int'(a[`OFFS_W-1:0]);
		for (int w = 0; w < `WAYS; w++) begin
			if (mValid[s][w] && mTag[s][w] == a[`ADDR_W-1 -: `TAG_W]) begin
				lo = mLine[s][w][8*off +: 8];
				// byte past the line end is zero
				hi = (off == 15) ? 8'h00 : mLine[s][w][8*(off+1) +: 8];
				return {1'b1, hi, lo};
			end
		end
		return 17'h0;
	endfunction

	function void modelWrite(addrT a, byteSelT sel, lineT data);
		int s;
		int way;
		s = int'(a[`OFFS_W +: `SET_W]);
		way = -1;
		for (int w = 0; w < `WAYS; w++)
			if (way < 0 && mValid[s][w] && mTag[s][w] == a[`ADDR_W-1 -: `TAG_W])
				way = w;
		// miss takes the lowest free way
		for (int w = 0; w < `WAYS; w++)
			if (way < 0 && !mValid[s][w]) begin
				way = w;
				mValid[s][w] = 1'b1;
				mTag[s][w] = a[`ADDR_W-1 -: `TAG_W];
			end
		if (way < 0)
			uncertain[s] = 1'b1;
		else
			for (int b = 0; b < `LINE_BYTES; b++)
				if (sel[b])
					mLine[s][way][8*b +: 8] = data[8*b +: 8];
	endfunction

	// one op per cycle with all inputs driven together
	task automatic drive(addrT a, logic wr, byteSelT sel, lineT data, logic nxt,
		logic invL, logic invA, logic chk);
		@(posedge clk);
		adr_i <= a;
		wr_i <= wr;
		sel_i <= sel;
		wdata_i <= data;
		nxt_i <= nxt;
		invLine_i <= invL;
		invAll_i <= invA;
		checkEn <= chk;
	endtask

	task automatic writeLine(addrT a, byteSelT sel, lineT data, logic nxt);
		drive(a, 1'b1, sel, data, nxt, 1'b0, 1'b0, 1'b0);
		modelWrite(a, sel, data);
	endtask

	task automatic readAt(addrT a);
		drive(a, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b1);
	endtask

	// unchecked read that hands back the raw hit flag
	task automatic probe(addrT a, output logic h);
		drive(a, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		@(negedge clk);
		h = hit_o;
	endtask

	task automatic idle();
		drive('0, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h expected %h at %h", name, got, exp, adr_i);
		end
	endtask

	task automatic checkWord(string name, wordT got, wordT exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h expected %h at %h", name, got, exp, adr_i);
		end
	endtask

	task automatic report(int num, string what, int errBefore);
		$display("test %0d %s: %0d errors", num, what, errors - errBefore);
	endtask

	// --------------------------------------------------------------------------
	// compare process sampling mid-cycle where outputs are settled
	// --------------------------------------------------------------------------

	always @(negedge clk) begin
		logic [16:0] exp;
		if (checkEn && !uncertain[adr_i[`OFFS_W +: `SET_W]]) begin
			exp = refRead(adr_i);
			checkBit("hit_o", hit_o, exp[16]);
			checkWord("rdata_o", rdata_o, exp[15:0]);
		end
	end

	// watchdog
	initial begin
		for (int c = 0; c < MAX_CYCLES && !done; c++)
			@(posedge clk);
		if (!done) begin
			$display("simulation did not finish within %0d cycles", MAX_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	// --------------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------------

	initial begin
		int errBefore;
		int oldHits;
		logic h;
		addrT a;
		clk = 1'b0;
		rst = 1'b1;
		adr_i = '0;
		wr_i = 1'b0;
		sel_i = '0;
		wdata_i = '0;
		nxt_i = 1'b0;
		invLine_i = 1'b0;
		invAll_i = 1'b0;
		checkEn = 1'b0;
		done = 1'b0;
		errors = 0;
		checks = 0;
		seed = 32'd47;
		for (int s = 0; s < `SETS; s++) begin
			uncertain[s] = 1'b0;
			for (int w = 0; w < `WAYS; w++) begin
				mValid[s][w] = 1'b0;
				mTag[s][w] = '0;
				mLine[s][w] = '0;
			end
			// low tag bits carry the slot number so tags in a set differ
			for (int k = 0; k < 5; k++)
				addrTab[s][k] = {22'(nextRand() >> 10), 3'(k), setIdxT'(s), 4'h0};
		end
		for (int c = 0; c < 8; c++)
			@(posedge clk);
		rst <= 1'b0;

		errBefore = errors;
		for (int i = 0; i < 20; i++)
			readAt(nextRand());
		idle();
		report(1, "reset misses", errBefore);

		// fill every set with four full lines
		errBefore = errors;
		for (int s = 0; s < `SETS; s++)
			for (int k = 0; k < `WAYS; k++)
				writeLine(addrTab[s][k], '1, randLine(), 1'b0);
		for (int s = 0; s < `SETS; s++)
			for (int k = 0; k < `WAYS; k++) begin
				readAt(addrTab[s][k] | addrT'(4'(nextRand())));
				readAt(addrTab[s][k] | addrT'(15));
			end
		idle();
		report(2, "full line fill", errBefore);

		errBefore = errors;
		for (int i = 0; i < 12; i++) begin
			a = addrTab[3'(nextRand())][2'(nextRand())];
			writeLine(a, byteSelT'(nextRand()), randLine(), 1'b0);
			for (int off = 0; off < `LINE_BYTES; off++)
				readAt(a | addrT'(off));
		end
		idle();
		report(3, "partial writes", errBefore);

		// fifth tag into set 2 forces an LFSR victim
		errBefore = errors;
		writeLine(addrTab[2][4], '1, randLine(), 1'b1);
		probe(addrTab[2][4], h);
		if (!h) begin
			errors++;
			$display("fifth tag written into a full set does not hit");
		end
		oldHits = 0;
		for (int k = 0; k < `WAYS; k++) begin
			probe(addrTab[2][k], h);
			if (h)
				oldHits++;
		end
		checks += 2;
		if (oldHits != 3) begin
			errors++;
			$display("%0d old tags still hit after eviction, 3 expected", oldHits);
		end
		idle();
		report(4, "eviction", errBefore);

		errBefore = errors;
		drive(addrTab[3][1], 1'b0, '0, '0, 1'b0, 1'b1, 1'b0, 1'b0);
		mValid[3][1] = 1'b0;
		for (int k = 0; k < `WAYS; k++)
			readAt(addrTab[3][k]);
		idle();
		report(5, "line invalidate", errBefore);

		errBefore = errors;
		drive('0, 1'b0, '0, '0, 1'b0, 1'b0, 1'b1, 1'b0);
		for (int s = 0; s < `SETS; s++) begin
			uncertain[s] = 1'b0;
			for (int w = 0; w < `WAYS; w++)
				mValid[s][w] = 1'b0;
		end
		for (int s = 0; s < `SETS; s++)
			for (int k = 0; k < 5; k++)
				readAt(addrTab[s][k]);
		idle();
		report(6, "invalidate all", errBefore);

		done = 1'b1;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
